// ==== all.f ====
+incdir+tests
design/gpio_pkg.sv
design/spi_pkg.sv
design/spi_byte_if.sv
design/reg_bus_if.sv
design/spi_shifter.sv
design/spi_cmd_ctrl.sv
design/gpio_bank.sv
design/spi2gpio_top.sv
tests/spi2gpio_asserts.sv
tests/tb_spi2gpio.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the spi2gpio testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing --timescale 1ns/1ps \
	--top-module tb_spi2gpio -f all.f -o sim_tb

# keep running past an assertion so the testbench reaches its verdict
./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "run failed, see sim.log"
	exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "no verdict found in sim.log"
	exit 1
fi

echo "run passed"

// ==== tests/spi_master_tasks.svh ====
// ###################################################################
// spi master, mode 0 bit-level drive of the dut pins
// ###################################################################

`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

// clk cycles per sclk phase
localparam int SCLK_HALF = 8;

task automatic wait_clks(input int n);
	repeat (n) @(posedge clk);
endtask

// cs low with sclk idle low
task automatic frame_begin();
	@(posedge clk);
	spi_sclk <= 1'b0;
	spi_cs_n <= 1'b0;
	wait_clks(SCLK_HALF);
endtask

// sclk back low, then cs high and a quiet gap
task automatic frame_end();
	@(posedge clk);
	spi_sclk <= 1'b0;
	wait_clks(SCLK_HALF);
	spi_cs_n <= 1'b1;
	wait_clks(2 * SCLK_HALF);
endtask

// one byte msb first, returns what came back on miso
task automatic xfer_byte(input spi_byte_t tx, output spi_byte_t rx);
	int i;
	for (i = SPI_BYTE_W - 1; i >= 0; i--) begin
		@(posedge clk);
		spi_sclk <= 1'b0;
		spi_mosi <= tx[i];
		wait_clks(SCLK_HALF - 1);
		// sample on the falling clk, just before sclk rises
		@(negedge clk);
		rx[i] = spi_miso;
		@(posedge clk);
		spi_sclk <= 1'b1;
		wait_clks(SCLK_HALF - 1);
	end
endtask

// single command/data pair in a frame of its own
task automatic access(input spi_byte_t cmd, input spi_byte_t data, output spi_byte_t reply);
	spi_byte_t cmd_rx;
	frame_begin();
	xfer_byte(cmd, cmd_rx);
	xfer_byte(data, reply);
	frame_end();
endtask

`endif

// ==== tests/tb_spi2gpio.sv ====
// ###################################################################
// testbench for the spi to gpio bridge, drives frames and checks
// register replies and port outputs against a register model
// ###################################################################

`timescale 1ns/1ps

module tb_spi2gpio
	import spi_pkg::*;
	import gpio_pkg::*;
();

	localparam int CLK_PERIOD_NS = 4;
	localparam spi_byte_t FILLER_EXP = 8'h5A;

	logic      clk;
	logic      rst_n;
	logic      spi_sclk;
	logic      spi_cs_n;
	logic      spi_mosi;
	logic      spi_miso;
	gpio_bus_t gpio_in;
	gpio_bus_t gpio_oe;
	gpio_bus_t gpio_out;

	`include "spi_master_tasks.svh"

	// frame budget, longest frame has four pairs plus cs gaps
	localparam int N_FRAMES    = 64;
	localparam int MAX_PAIRS   = 4;
	localparam int FRAME_CLKS  = MAX_PAIRS * 2 * SPI_BYTE_W * (2 * SCLK_HALF + 1) + 4 * SCLK_HALF;
	localparam int WATCHDOG_NS = N_FRAMES * FRAME_CLKS * 2 * CLK_PERIOD_NS;

	// register model
	gpio_bus_t mdl_oe;
	gpio_bus_t mdl_out;

	// results waiting for the compare process
	spi_byte_t byte_got_q[$];
	spi_byte_t byte_exp_q[$];
	string     byte_name_q[$];
	gpio_bus_t bus_got_q[$];
	gpio_bus_t bus_exp_q[$];
	string     bus_name_q[$];

	int checks = 0;
	int errors = 0;
	int tests_run = 0;
	int errs_at_start = 0;

	spi2gpio_top u_spi2gpio_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_spi_sclk (spi_sclk),
		.i_spi_cs_n (spi_cs_n),
		.i_spi_mosi (spi_mosi),
		.o_spi_miso (spi_miso),
		.i_gpio_in  (gpio_in),
		.o_gpio_oe  (gpio_oe),
		.o_gpio_out (gpio_out)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD_NS / 2) clk = ~clk;

	function automatic spi_byte_t cmd_byte(input logic wr, input logic [GPIO_ADDR_W-1:0] addr);
		return {wr, 2'b00, addr};
	endfunction

	// ports a..e in slots 0..4, z in slot 7
	function automatic logic slot_exists(input logic [2:0] slot);
		return (slot <= 3'd4) || (slot == 3'd7);
	endfunction

	function automatic logic [2:0] valid_slot();
		logic [2:0] s;
		s = 3'($urandom_range(0, 5));
		return (s == 3'd5) ? 3'd7 : s;
	endfunction

	// anything but an enable or value register of a real port
	function automatic logic [GPIO_ADDR_W-1:0] unused_addr();
		logic [GPIO_ADDR_W-1:0] a;
		a = 5'($urandom);
		while (slot_exists(a[4:2]) && !a[1])
			a = 5'($urandom);
		return a;
	endfunction

	function automatic void model_reset();
		mdl_oe     = '0;
		mdl_out    = '0;
		mdl_oe[7]  = 8'h80;
		mdl_out[7] = 8'h80;
	endfunction

	// live input, offset 3 and holes take no write
	function automatic void model_write(input logic [GPIO_ADDR_W-1:0] addr, input spi_byte_t data);
		if (slot_exists(addr[4:2]) && addr[1:0] == 2'd0)
			mdl_oe[addr[4:2]] = data;
		if (slot_exists(addr[4:2]) && addr[1:0] == 2'd1)
			mdl_out[addr[4:2]] = data;
	endfunction

	// expected reply for a read of addr
	function automatic spi_byte_t ref_read(input logic [GPIO_ADDR_W-1:0] addr, input gpio_bus_t pins);
		if (!slot_exists(addr[4:2]))
			return 8'h00;
		case (addr[1:0])
		2'd0:    return mdl_oe[addr[4:2]];
		2'd1:    return mdl_out[addr[4:2]];
		2'd2:    return pins[addr[4:2]];
		default: return 8'h00;
		endcase
	endfunction

	task automatic check_byte(input string what, input spi_byte_t got, input spi_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic check_bus(input string what, input gpio_bus_t got, input gpio_bus_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got 0x%016h expected 0x%016h", $time, what, got, exp);
		end
	endtask

	task automatic expect_byte(input string what, input spi_byte_t got, input spi_byte_t exp);
		byte_name_q.push_back(what);
		byte_got_q.push_back(got);
		byte_exp_q.push_back(exp);
	endtask

	// port outputs against the model, taken mid cycle
	task automatic expect_outputs();
		@(negedge clk);
		bus_name_q.push_back("o_gpio_oe");
		bus_got_q.push_back(gpio_oe);
		bus_exp_q.push_back(mdl_oe);
		bus_name_q.push_back("o_gpio_out");
		bus_got_q.push_back(gpio_out);
		bus_exp_q.push_back(mdl_out);
	endtask

	task automatic do_write(input logic [GPIO_ADDR_W-1:0] addr, input spi_byte_t data);
		spi_byte_t rx;
		access(cmd_byte(1'b1, addr), data, rx);
		model_write(addr, data);
	endtask

	task automatic do_read(input logic [GPIO_ADDR_W-1:0] addr);
		spi_byte_t rx;
		access(cmd_byte(1'b0, addr), 8'h00, rx);
		expect_byte($sformatf("o_spi_miso read 0x%02h", addr), rx, ref_read(addr, gpio_in));
	endtask

	// drain pending compares, then one line for the test
	task automatic finish_test(input string name);
		while (byte_got_q.size() != 0 || bus_got_q.size() != 0)
			@(posedge clk);
		tests_run++;
		$display("test %0d %-24s %0d errors", tests_run, name, errors - errs_at_start);
		errs_at_start = errors;
	endtask

	initial begin : compare
		forever begin
			@(negedge clk);
			while (byte_got_q.size() != 0)
				check_byte(byte_name_q.pop_front(), byte_got_q.pop_front(),
					byte_exp_q.pop_front());
			while (bus_got_q.size() != 0)
				check_bus(bus_name_q.pop_front(), bus_got_q.pop_front(),
					bus_exp_q.pop_front());
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : stimulus
		logic [GPIO_ADDR_W-1:0] addr;
		spi_byte_t data;
		spi_byte_t rx;
		spi_byte_t rx_cmd;
		int i;
		void'($urandom(38923));
		rst_n    <= 1'b0;
		spi_sclk <= 1'b0;
		spi_cs_n <= 1'b1;
		spi_mosi <= 1'b0;
		gpio_in  <= '0;
		model_reset();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		wait_clks(4);

		// enable and value of every real port
		for (i = 0; i < GPIO_SLOTS; i++) begin
			if (slot_exists(3'(i))) begin
				do_read({3'(i), 2'd0});
				do_read({3'(i), 2'd1});
			end
		end
		expect_outputs();
		finish_test("reset values");

		for (i = 0; i < 10; i++) begin
			addr = {valid_slot(), 1'b0, 1'($urandom)};
			data = spi_byte_t'($urandom);
			do_write(addr, data);
			expect_outputs();
			do_read(addr);
		end
		finish_test("random writes");

		// pins change only between frames
		for (i = 0; i < 6; i++) begin
			@(posedge clk);
			gpio_in <= {$urandom, $urandom};
			do_read({valid_slot(), 2'd2});
		end
		finish_test("live input reads");

		for (i = 0; i < 8; i++) begin
			do_write(unused_addr(), spi_byte_t'($urandom));
			expect_outputs();
			do_read(unused_addr());
		end
		finish_test("unused registers");

		// write, read back, write, read back in one frame
		frame_begin();
		for (i = 0; i < MAX_PAIRS; i++) begin
			if (i % 2 == 0) begin
				addr = {valid_slot(), 1'b0, 1'($urandom)};
				data = spi_byte_t'($urandom);
				xfer_byte(cmd_byte(1'b1, addr), rx_cmd);
				xfer_byte(data, rx);
				model_write(addr, data);
			end else begin
				xfer_byte(cmd_byte(1'b0, addr), rx_cmd);
				xfer_byte(8'h00, rx);
				expect_byte("o_spi_miso pair read", rx, ref_read(addr, gpio_in));
			end
			expect_byte("o_spi_miso filler", rx_cmd, FILLER_EXP);
		end
		// trailing byte shows the filler after the last data byte
		xfer_byte(cmd_byte(1'b0, 5'd0), rx_cmd);
		expect_byte("o_spi_miso filler", rx_cmd, FILLER_EXP);
		frame_end();
		expect_outputs();
		finish_test("multi pair frame");

		// lone write command to port a enable, then cs high
		frame_begin();
		xfer_byte(cmd_byte(1'b1, 5'd0), rx_cmd);
		frame_end();
		// a stale data phase would write 0x81 into port a enable
		do_write(5'd1, spi_byte_t'($urandom));
		expect_outputs();
		do_read(5'd1);
		do_read(5'd0);
		finish_test("deselect mid pair");

		$display("tests %0d  checks %0d  errors %0d  assertion failures %0d", tests_run,
			checks, errors, u_spi2gpio_top.u_spi_cmd_ctrl.u_ctrl_asserts.fail_cnt);
		if (errors == 0 && u_spi2gpio_top.u_spi_cmd_ctrl.u_ctrl_asserts.fail_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== tests/spi2gpio_asserts.sv ====
// ###################################################################
// protocol checks inside the spi command controller
// ###################################################################

`timescale 1ns/1ps

module spi2gpio_asserts
	import spi_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       byte_stb,
	input logic       load_stb,
	input logic       wr_stb,
	input spi_phase_e phase
);

	// failures seen so far, read by the testbench at the end
	int unsigned fail_cnt = 0;

	// byte strobe from the shifter is a single pulse
	a_byte_stb_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		byte_stb |=> !byte_stb)
	else begin
		fail_cnt++;
		$error("byte_stb held high for more than one cycle");
	end

	// reply load comes exactly one cycle after the byte
	a_load_follows: assert property (@(posedge clk) disable iff (!rst_n)
		load_stb == $past(byte_stb))
	else begin
		fail_cnt++;
		$error("load_stb not one cycle behind byte_stb");
	end

	// register writes only with a data byte
	a_wr_in_data: assert property (@(posedge clk) disable iff (!rst_n)
		wr_stb |-> phase == PH_DATA)
	else begin
		fail_cnt++;
		$error("wr_stb outside the data phase");
	end

endmodule

bind spi_cmd_ctrl spi2gpio_asserts u_ctrl_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.byte_stb (byte_bus.byte_stb),
	.load_stb (byte_bus.load_stb),
	.wr_stb   (reg_bus.wr_stb),
	.phase    (phase_q)
);

// ==== design/spi2gpio_top.sv ====
// ###################################################################
// spi slave to gpio bridge, top level
// ###################################################################

`timescale 1ns/1ps

module spi2gpio_top
	import gpio_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// spi slave pins
	input  logic      i_spi_sclk,
	input  logic      i_spi_cs_n,
	input  logic      i_spi_mosi,
	output logic      o_spi_miso,

	// ports, one byte per slot, tristate lives in the pad ring
	input  gpio_bus_t i_gpio_in,
	output gpio_bus_t o_gpio_oe,
	output gpio_bus_t o_gpio_out
);

	spi_byte_if u_byte_if ();
	reg_bus_if  u_reg_bus ();

	// pins in, bytes out
	spi_shifter u_spi_shifter (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sclk   (i_spi_sclk),
		.i_cs_n   (i_spi_cs_n),
		.i_mosi   (i_spi_mosi),
		.o_miso   (o_spi_miso),
		.byte_bus (u_byte_if.shifter_mp)
	);

	// command/data decode
	spi_cmd_ctrl u_spi_cmd_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.byte_bus (u_byte_if.ctrl_mp),
		.reg_bus  (u_reg_bus.master_mp)
	);

	gpio_bank u_gpio_bank (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_gpio_in  (i_gpio_in),
		.o_gpio_oe  (o_gpio_oe),
		.o_gpio_out (o_gpio_out),
		.reg_bus    (u_reg_bus.slave_mp)
	);

endmodule

// ==== design/gpio_bank.sv ====
// ###################################################################
// gpio port bank: enable/value registers per slot and read mux
// ###################################################################

`timescale 1ns/1ps

module gpio_bank
	import gpio_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  gpio_bus_t i_gpio_in,
	output gpio_bus_t o_gpio_oe,
	output gpio_bus_t o_gpio_out,
	reg_bus_if.slave_mp reg_bus
);

	// address fields
	logic [GPIO_SLOT_W-1:0] wr_slot;
	logic [GPIO_OFS_W-1:0]  wr_ofs;
	logic [GPIO_SLOT_W-1:0] rd_slot;
	logic [GPIO_OFS_W-1:0]  rd_ofs;

	gpio_word_t rd_word;

	assign wr_slot = reg_bus.wr_addr[GPIO_ADDR_W-1 -: GPIO_SLOT_W];
	assign wr_ofs  = reg_bus.wr_addr[GPIO_OFS_W-1:0];
	assign rd_slot = reg_bus.rd_addr[GPIO_ADDR_W-1 -: GPIO_SLOT_W];
	assign rd_ofs  = reg_bus.rd_addr[GPIO_OFS_W-1:0];

	for (genvar s = 0; s < GPIO_SLOTS; s++) begin : g_slot
		if (gpio_slot_valid[s]) begin : g_port
			gpio_word_t oe_q;
			gpio_word_t out_q;
			logic       sel;

			assign sel = reg_bus.wr_stb && (wr_slot == GPIO_SLOT_W'(s));

			// reset words come per slot from the package
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					oe_q  <= GPIO_RST_OE[s];
					out_q <= GPIO_RST_OUT[s];
				end else if (sel) begin
					// live input and offset 3 ignore writes
					if (wr_ofs == REG_OE)
						oe_q <= reg_bus.wr_data;
					if (wr_ofs == REG_OUT)
						out_q <= reg_bus.wr_data;
				end
			end

			assign o_gpio_oe[s]  = oe_q;
			assign o_gpio_out[s] = out_q;
		end else begin : g_hole
			// no port here, pins stay quiet
			assign o_gpio_oe[s]  = '0;
			assign o_gpio_out[s] = '0;
		end
	end

	// holes and offset 3 read back as zero
	always_comb begin
		rd_word = '0;
		if (gpio_slot_valid[rd_slot]) begin
			case (rd_ofs)
			REG_OE:  rd_word = o_gpio_oe[rd_slot];
			REG_OUT: rd_word = o_gpio_out[rd_slot];
			REG_IN:  rd_word = i_gpio_in[rd_slot];
			default: rd_word = '0;
			endcase
		end
	end

	assign reg_bus.rd_data = rd_word;

endmodule

// ==== design/spi_cmd_ctrl.sv ====
// ###################################################################
// spi command controller: phase tracking, register strobes, reply
// ###################################################################

`timescale 1ns/1ps

module spi_cmd_ctrl
	import spi_pkg::*;
	import gpio_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	spi_byte_if.ctrl_mp  byte_bus,
	reg_bus_if.master_mp reg_bus
);

	spi_phase_e phase_q;

	// received byte seen as command or as raw data
	spi_byte_u rx;

	logic is_cmd;
	logic is_data;

	// write command held over for the data byte
	logic                   wr_flag_q;
	logic [GPIO_ADDR_W-1:0] wr_addr_q;

	spi_byte_t reply_q;
	logic      load_q;

	assign rx      = byte_bus.rx_byte;
	assign is_cmd  = byte_bus.byte_stb && (phase_q == PH_CMD);
	assign is_data = byte_bus.byte_stb && (phase_q == PH_DATA);

	// deselect wins, a half frame never leaks into the next
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= PH_CMD;
		end else if (byte_bus.deselect) begin
			phase_q <= PH_CMD;
		end else if (byte_bus.byte_stb) begin
			phase_q <= (phase_q == PH_CMD) ? PH_DATA : PH_CMD;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_flag_q <= 1'b0;
			wr_addr_q <= '0;
		end else if (is_cmd) begin
			wr_flag_q <= rx.cmd.wr;
			wr_addr_q <= rx.cmd.addr;
		end
	end

	// write goes out with the data byte strobe
	assign reg_bus.wr_stb  = is_data && wr_flag_q;
	assign reg_bus.wr_addr = wr_addr_q;
	assign reg_bus.wr_data = rx.raw;

	// read address straight from the command byte in flight
	assign reg_bus.rd_addr = rx.cmd.addr;

	// read data captured at the command byte, shifted during data byte
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reply_q <= SPI_FILLER;
		end else if (is_cmd && !rx.cmd.wr) begin
			reply_q <= reg_bus.rd_data;
		end else if (is_data) begin
			reply_q <= SPI_FILLER;
		end
	end

	// reply is ready one cycle after the strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			load_q <= 1'b0;
		else
			load_q <= byte_bus.byte_stb;
	end

	assign byte_bus.load_stb = load_q;
	assign byte_bus.tx_byte  = reply_q;

endmodule

// ==== design/spi_shifter.sv ====
// ###################################################################
// spi slave shifter: pin sync, msb-first shift in/out, byte strobe
// ###################################################################

`timescale 1ns/1ps

module spi_shifter
	import spi_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic i_sclk,
	input  logic i_cs_n,
	input  logic i_mosi,
	output logic o_miso,
	spi_byte_if.shifter_mp byte_bus
);

	// first stage samples the pins, second is the delayed copy
	logic sclk_r, sclk_d;
	logic cs_r, cs_d;
	logic mosi_r, mosi_d;

	// registered rising edge of sclk, only while selected
	logic rise_q;
	logic frame_start;

	// one-hot bit position, top bit set means 8 bits in
	logic [SPI_BYTE_W:0] bit_cnt;
	spi_byte_t           shift_q;
	logic                byte_stb_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sclk_r <= 1'b0;
			sclk_d <= 1'b0;
			cs_r   <= 1'b1;
			cs_d   <= 1'b1;
			mosi_r <= 1'b0;
			mosi_d <= 1'b0;
		end else begin
			sclk_r <= i_sclk;
			sclk_d <= sclk_r;
			cs_r   <= i_cs_n;
			cs_d   <= cs_r;
			mosi_r <= i_mosi;
			// keeps mosi lined up with rise_q
			mosi_d <= mosi_r;
		end
	end

	// cs falling starts a frame, cs rising ends it
	assign frame_start = cs_d & ~cs_r;
	assign byte_bus.deselect = cs_r & ~cs_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rise_q <= 1'b0;
		else
			rise_q <= sclk_r & ~sclk_d & ~cs_r;
	end

	// restart on new frame and once the byte is counted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= (SPI_BYTE_W+1)'(1);
		end else if (frame_start || bit_cnt[SPI_BYTE_W]) begin
			bit_cnt <= (SPI_BYTE_W+1)'(1);
		end else if (rise_q) begin
			bit_cnt <= {bit_cnt[SPI_BYTE_W-1:0], 1'b0};
		end
	end

	// reply load lands well before the next sclk edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift_q <= '0;
		end else if (byte_bus.load_stb) begin
			shift_q <= byte_bus.tx_byte;
		end else if (rise_q) begin
			// msb first, new bit enters at the bottom
			shift_q <= {shift_q[SPI_BYTE_W-2:0], mosi_d};
		end
	end

	// single pulse, counter clears on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			byte_stb_q <= 1'b0;
		else
			byte_stb_q <= bit_cnt[SPI_BYTE_W];
	end

	assign byte_bus.byte_stb = byte_stb_q;
	assign byte_bus.rx_byte  = shift_q;

	// master samples before each rising edge
	assign o_miso = shift_q[SPI_BYTE_W-1];

endmodule

// ==== design/reg_bus_if.sv ====
// ###################################################################
// register access bus from command controller to port registers
// ###################################################################

`timescale 1ns/1ps

interface reg_bus_if
	import gpio_pkg::*;
();

	// write, taken on the cycle wr_stb is high
	logic                   wr_stb;
	logic [GPIO_ADDR_W-1:0] wr_addr;
	gpio_word_t             wr_data;

	// read, rd_data follows rd_addr combinationally
	logic [GPIO_ADDR_W-1:0] rd_addr;
	gpio_word_t             rd_data;

	modport master_mp (
		output wr_stb, wr_addr, wr_data, rd_addr,
		input  rd_data
	);

	modport slave_mp (
		input  wr_stb, wr_addr, wr_data, rd_addr,
		output rd_data
	);

endinterface

// ==== design/spi_byte_if.sv ====
// ###################################################################
// byte handshake between spi shifter and command controller
// ###################################################################

`timescale 1ns/1ps

interface spi_byte_if
	import spi_pkg::*;
();

	// shifter side
	logic      byte_stb;
	logic      deselect;
	spi_byte_t rx_byte;

	// controller side
	logic      load_stb;
	spi_byte_t tx_byte;

	modport shifter_mp (
		output byte_stb, rx_byte, deselect,
		input  load_stb, tx_byte
	);

	modport ctrl_mp (
		input  byte_stb, rx_byte, deselect,
		output load_stb, tx_byte
	);

endinterface

// ==== design/spi_pkg.sv ====
// ###################################################################
// spi byte views, command/data phase and reply filler
// ###################################################################

package spi_pkg;

	import gpio_pkg::*;

	localparam int SPI_BYTE_W = 8;

	typedef logic [SPI_BYTE_W-1:0] spi_byte_t;

	// command byte: bit 7 write, bits 6..5 ignored, bits 4..0 register
	typedef struct packed {
		logic                   wr;
		logic [1:0]             rsvd;
		logic [GPIO_ADDR_W-1:0] addr;
	} spi_cmd_t;

	// same received byte, decoded by phase
	typedef union packed {
		spi_cmd_t  cmd;
		spi_byte_t raw;
	} spi_byte_u;

	// bytes alternate command, data, command ...
	typedef enum logic {
		PH_CMD  = 1'b0,
		PH_DATA = 1'b1
	} spi_phase_e;

	// shifted out after every data byte
	localparam spi_byte_t SPI_FILLER = 8'h5A;

endpackage

// ==== design/gpio_pkg.sv ====
// ###################################################################
// gpio register map: address fields, port slots and reset words
// ###################################################################

package gpio_pkg;

	// one port is a full byte of pins
	localparam int GPIO_W = 8;

	typedef logic [GPIO_W-1:0] gpio_word_t;

	// register address {slot[2:0], offset[1:0]}
	localparam int GPIO_ADDR_W = 5;
	localparam int GPIO_OFS_W  = 2;
	localparam int GPIO_SLOT_W = GPIO_ADDR_W - GPIO_OFS_W;

	// a..e in slots 0..4, z in slot 7
	localparam int GPIO_SLOTS = 8;

	// slots 5 and 6 are holes in the map
	localparam logic [GPIO_SLOTS-1:0] gpio_slot_valid = 8'h9F;

	// offsets inside one port slot, offset 3 unused
	localparam logic [GPIO_OFS_W-1:0] REG_OE  = 2'd0;
	localparam logic [GPIO_OFS_W-1:0] REG_OUT = 2'd1;
	localparam logic [GPIO_OFS_W-1:0] REG_IN  = 2'd2;

	// all ports side by side, index is the slot number
	typedef gpio_word_t [GPIO_SLOTS-1:0] gpio_bus_t;

	// port z comes up with pin 7 driven high
	localparam gpio_bus_t GPIO_RST_OE = {
		8'h80, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'h00, 8'h00
	};
	localparam gpio_bus_t GPIO_RST_OUT = {
		8'h80, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'h00, 8'h00
	};

endpackage
